// ==== verilog/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // frame layout: start, data bits lsb first, even parity, stop.
  localparam int data_bits = 8;
  localparam int frame_bits = 11;

  // write gap and read response wait, counted in bit periods.
  localparam int gap_bits = 2;
  localparam int resp_timeout_bits = 32;

  typedef logic [data_bits-1:0] uart_byte_t;

  typedef logic [6:0] reg_addr_t;

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  // host command word, op in bit 15.
  typedef struct packed
  {
    cmd_op_e    op;
    reg_addr_t  addr;
    uart_byte_t data;
  } cmd_t;

  typedef enum logic [2:0]
  {
    st_idle,
    st_judge,
    st_send_addr,
    st_gap,
    st_send_data,
    st_wait_resp,
    st_report
  } ctrl_state_e;

endpackage

// ==== verilog/uart_baud_gen.sv ====
`timescale 1ns/10ps

module uart_baud_gen #(
  parameter int clks_per_bit = 434
) (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic bit_tick,
  output logic half_tick
);

  localparam int cnt_w = $clog2(clks_per_bit);

  logic [cnt_w-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
    end
    else if (!en || bit_tick)
    begin
      cnt <= '0; // restart with each frame.
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick  = en && (cnt == cnt_w'(clks_per_bit - 1));
  assign half_tick = en && (cnt == cnt_w'(clks_per_bit / 2 - 1)); // mid-bit point.

endmodule

// ==== verilog/uart_frame_tx.sv ====
`timescale 1ns/10ps

module uart_frame_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx_start,
  input  uart_cmd_pkg::uart_byte_t tx_byte,
  output logic                   tx_busy,
  output logic                   tx
);

  logic       bit_tick;
  logic [9:0] shreg; // data, parity, stop.
  logic [3:0] bit_cnt;

  uart_baud_gen #(
    .clks_per_bit (clks_per_bit)
  ) i_baud (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (tx_busy),
    .bit_tick  (bit_tick),
    .half_tick ()
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      bit_cnt <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        tx      <= 1'b0; // start bit.
        bit_cnt <= '0;
      end
    end
    else if (bit_tick)
    begin
      tx      <= shreg[0];
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 4'(uart_cmd_pkg::frame_bits - 1))
      begin
        tx_busy <= 1'b0; // end of stop bit.
      end
    end
  end

  // payload shifter, ones fill in behind the stop bit.
  always_ff @(posedge clk)
  begin
    if (!tx_busy && tx_start)
    begin
      shreg <= {1'b1, ^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_tick)
    begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

// ==== verilog/uart_frame_rx.sv ====
`timescale 1ns/10ps

module uart_frame_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx_en,
  input  logic                     rx,
  output logic                     rx_active,
  output logic                     rx_done,
  output logic                     rx_perr,
  output uart_cmd_pkg::uart_byte_t rx_byte
);

  logic [1:0] rx_sync;
  logic       rx_s;
  logic       rx_q;
  logic       half_tick;
  logic [3:0] bit_idx; // 0 start, 1..8 data, 9 parity, 10 stop.
  logic       par_bad;

  assign rx_s = rx_sync[1];

  uart_baud_gen #(
    .clks_per_bit (clks_per_bit)
  ) i_baud (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (rx_active),
    .bit_tick  (),
    .half_tick (half_tick)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync   <= 2'b11;
      rx_q      <= 1'b1;
      rx_active <= 1'b0;
      rx_done   <= 1'b0;
      rx_perr   <= 1'b0;
      bit_idx   <= '0;
      par_bad   <= 1'b0;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_q    <= rx_s;
      rx_done <= 1'b0;
      if (!rx_active)
      begin
        if (rx_en && rx_q && !rx_s)
        begin
          rx_active <= 1'b1; // falling edge, maybe a start bit.
          bit_idx   <= '0;
        end
      end
      else if (half_tick)
      begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_s)
        begin
          rx_active <= 1'b0; // glitch, not a start bit.
        end
        else if (bit_idx == 4'(uart_cmd_pkg::data_bits + 1))
        begin
          par_bad <= (^rx_byte) ^ rx_s;
        end
        else if (bit_idx == 4'(uart_cmd_pkg::frame_bits - 1))
        begin
          rx_active <= 1'b0;
          rx_done   <= 1'b1;
          rx_perr   <= par_bad || !rx_s; // parity or framing error.
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_active && half_tick && bit_idx != '0 &&
        bit_idx <= 4'(uart_cmd_pkg::data_bits))
    begin
      rx_byte <= {rx_s, rx_byte[7:1]}; // lsb arrives first.
    end
  end

endmodule

// ==== verilog/uart_cmd_ctrl.sv ====
`timescale 1ns/10ps

module uart_cmd_ctrl #(
  parameter int clks_per_bit = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  input  logic                     tx_busy,
  input  logic                     rx_active,
  input  logic                     rx_done,
  input  logic                     rx_perr,
  input  uart_cmd_pkg::uart_byte_t rx_byte,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic                     rx_en,
  output logic                     read_rdy,
  output logic                     read_err,
  output uart_cmd_pkg::uart_byte_t tx_byte,
  output uart_cmd_pkg::uart_byte_t read_data
);

  localparam int cw = $clog2(clks_per_bit);
  localparam int bw = $clog2(uart_cmd_pkg::resp_timeout_bits);

  uart_cmd_pkg::ctrl_state_e state;
  uart_cmd_pkg::ctrl_state_e next_state;
  uart_cmd_pkg::cmd_t        cmd_q;
  uart_cmd_pkg::cmd_op_e     op_q;

  logic [cw-1:0] clk_cnt;
  logic [bw-1:0] bit_cnt;
  logic          bit_end;
  logic          counting;
  logic          gap_done;
  logic          resp_timeout;

  assign bit_end  = clk_cnt == cw'(clks_per_bit - 1);
  // timer pauses while a response frame is coming in.
  assign counting = (state == uart_cmd_pkg::st_gap) ||
                    (state == uart_cmd_pkg::st_wait_resp && !rx_active);
  assign gap_done = (state == uart_cmd_pkg::st_gap) && bit_end &&
                    (bit_cnt == bw'(uart_cmd_pkg::gap_bits - 1));
  assign resp_timeout = (state == uart_cmd_pkg::st_wait_resp) && !rx_active && bit_end &&
                        (bit_cnt == bw'(uart_cmd_pkg::resp_timeout_bits - 1));

  assign cmd_rdy  = state == uart_cmd_pkg::st_idle;
  assign rx_en    = state == uart_cmd_pkg::st_wait_resp;
  assign read_rdy = state == uart_cmd_pkg::st_report;
  assign tx_start = (state == uart_cmd_pkg::st_judge) || gap_done;
  assign tx_byte  = (state == uart_cmd_pkg::st_gap) ? cmd_q.data : {cmd_q.op, cmd_q.addr};

  always_comb
  begin
    next_state = state;
    case (state)
      uart_cmd_pkg::st_idle:
        if (cmd_vld)
          next_state = uart_cmd_pkg::st_judge;
      uart_cmd_pkg::st_judge:
        next_state = uart_cmd_pkg::st_send_addr;
      uart_cmd_pkg::st_send_addr:
        if (!tx_busy)
          next_state = (op_q == uart_cmd_pkg::op_write) ? uart_cmd_pkg::st_gap :
                                                          uart_cmd_pkg::st_wait_resp;
      uart_cmd_pkg::st_gap:
        if (gap_done)
          next_state = uart_cmd_pkg::st_send_data;
      uart_cmd_pkg::st_send_data:
        if (!tx_busy)
          next_state = uart_cmd_pkg::st_idle;
      uart_cmd_pkg::st_wait_resp:
        if (rx_done || resp_timeout)
          next_state = uart_cmd_pkg::st_report;
      default:
        next_state = uart_cmd_pkg::st_idle; // report lasts one cycle.
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= uart_cmd_pkg::st_idle;
      op_q    <= uart_cmd_pkg::op_read;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      if (state == uart_cmd_pkg::st_judge)
      begin
        op_q <= cmd_q.op; // decode once.
      end
      if (counting)
      begin
        clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
        if (bit_end)
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else if (state != uart_cmd_pkg::st_wait_resp)
      begin
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
    end
    if (state == uart_cmd_pkg::st_wait_resp && rx_done)
    begin
      read_data <= rx_byte;
      read_err  <= rx_perr;
    end
    else if (resp_timeout)
    begin
      read_data <= '0; // no answer.
      read_err  <= 1'b1;
    end
  end

endmodule

// ==== verilog/uart_cmd_top.sv ====
`timescale 1ns/10ps

module uart_cmd_top #(
  parameter int clks_per_bit = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  input  logic                     rx,
  output logic                     cmd_rdy,
  output logic                     tx,
  output logic                     read_rdy,
  output logic                     read_err,
  output uart_cmd_pkg::uart_byte_t read_data
);

  uart_cmd_pkg::uart_byte_t tx_byte;
  uart_cmd_pkg::uart_byte_t rx_byte;
  logic                     tx_start;
  logic                     tx_busy;
  logic                     rx_en;
  logic                     rx_active;
  logic                     rx_done;
  logic                     rx_perr;

  uart_cmd_ctrl #(
    .clks_per_bit (clks_per_bit)
  ) i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .rx_active (rx_active),
    .rx_done   (rx_done),
    .rx_perr   (rx_perr),
    .rx_byte   (rx_byte),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .rx_en     (rx_en),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .tx_byte   (tx_byte),
    .read_data (read_data)
  );

  uart_frame_tx #(
    .clks_per_bit (clks_per_bit)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_frame_rx #(
    .clks_per_bit (clks_per_bit)
  ) i_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_en     (rx_en),
    .rx        (rx),
    .rx_active (rx_active),
    .rx_done   (rx_done),
    .rx_perr   (rx_perr),
    .rx_byte   (rx_byte)
  );

endmodule

// ==== bench/uart_slave_model.sv ====
`timescale 1ns/10ps

module uart_slave_model #(
  parameter int clks_per_bit = 434
) (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  input  logic corrupt_parity,
  input  logic silent,
  output logic rx,
  output logic frame_err,
  output int   addr_frames
);

  uart_cmd_pkg::uart_byte_t regs [0:127];
  uart_cmd_pkg::uart_byte_t hdr;
  uart_cmd_pkg::uart_byte_t wdata;
  uart_cmd_pkg::reg_addr_t  addr;
  uart_cmd_pkg::cmd_op_e    op;

  // samples each bit in the middle, on the falling clock edge.
  task automatic recv_frame(output uart_cmd_pkg::uart_byte_t b);
    logic start;
    logic par;
    logic stop;
    int   i;
    @(negedge tx);
    repeat (clks_per_bit / 2) @(negedge clk);
    start = tx;
    for (i = 0; i < 8; i++)
    begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = tx; // lsb first.
    end
    repeat (clks_per_bit) @(negedge clk);
    par = tx;
    repeat (clks_per_bit) @(negedge clk);
    stop = tx;
    if (start || (par != ^b) || !stop)
    begin
      $display("slave model: broken command frame, byte %h", b);
      frame_err = 1'b1;
    end
  endtask

  task automatic send_frame(input uart_cmd_pkg::uart_byte_t b);
    logic [9:0] bits;
    int         i;
    bits = {(^b) ^ corrupt_parity, b, 1'b0};
    for (i = 0; i < 10; i++)
    begin
      rx = bits[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    rx = 1'b1; // stop bit, then idle.
  endtask

  initial
  begin
    rx          = 1'b1;
    frame_err   = 1'b0;
    addr_frames = 0;
    for (int i = 0; i < 128; i++)
    begin
      regs[i] = 8'(i) ^ 8'h5a;
    end
    wait (rst_n === 1'b1);
    forever
    begin
      recv_frame(hdr);
      addr_frames++;
      op   = uart_cmd_pkg::cmd_op_e'(hdr[7]);
      addr = hdr[6:0];
      if (op == uart_cmd_pkg::op_write)
      begin
        recv_frame(wdata);
        regs[addr] = wdata;
      end
      else if (!silent)
      begin
        // half the stop bit plus three idle bits.
        repeat (clks_per_bit / 2 + 3 * clks_per_bit) @(negedge clk);
        send_frame(regs[addr]);
      end
    end
  end

endmodule

// ==== bench/uart_cmd_tb.sv ====
`timescale 1ns/10ps

module uart_cmd_tb;

  localparam int clks_per_bit   = 16;
  localparam int num_pairs      = 40;
  localparam int num_cmds       = 2 * num_pairs + 4;
  localparam int timeout_cycles = num_cmds * 80 * clks_per_bit + 1000;
  localparam int write_cycles   =
    (2 * uart_cmd_pkg::frame_bits + uart_cmd_pkg::gap_bits) * clks_per_bit + 3;

  logic                     clk;
  logic                     rst_n;
  uart_cmd_pkg::cmd_t       cmd_in;
  logic                     cmd_vld;
  logic                     rx;
  logic                     cmd_rdy;
  logic                     tx;
  logic                     read_rdy;
  logic                     read_err;
  uart_cmd_pkg::uart_byte_t read_data;
  logic                     corrupt_parity;
  logic                     silent;
  logic                     frame_err;
  int                       addr_frames;

  uart_cmd_pkg::uart_byte_t shadow [0:127];
  logic                     written [0:127];
  uart_cmd_pkg::uart_byte_t exp_data_q [$];
  logic                     exp_err_q [$];
  uart_cmd_pkg::uart_byte_t want_data;
  logic                     want_err;
  uart_cmd_pkg::reg_addr_t  waddr;
  uart_cmd_pkg::reg_addr_t  raddr;
  logic [31:0]              rand_state;
  int cmds_issued  = 0;
  int reads_issued = 0;
  int reads_done   = 0;
  int accepts      = 0;
  int cycles       = 0;
  int turnaround;

  uart_cmd_top #(
    .clks_per_bit (clks_per_bit)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .read_data (read_data)
  );

  uart_slave_model #(
    .clks_per_bit (clks_per_bit)
  ) i_slave (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .silent         (silent),
    .rx             (rx),
    .frame_err      (frame_err),
    .addr_frames    (addr_frames)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // last written value, else the slave's power-up pattern.
  function automatic uart_cmd_pkg::uart_byte_t expected_read(input uart_cmd_pkg::reg_addr_t a);
    if (written[a])
      return shadow[a];
    else
      return {1'b0, a} ^ 8'h5a;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input uart_cmd_pkg::uart_byte_t got,
                            input uart_cmd_pkg::uart_byte_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      fail_now($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // called on a falling edge, returns on the falling edge after the handshake.
  task automatic drive_cmd(input uart_cmd_pkg::cmd_t c);
    cmd_in  = c;
    cmd_vld = 1'b1;
    cmds_issued++;
    while (!cmd_rdy) @(negedge clk);
    @(negedge clk);
    check_flag(cmd_rdy, 1'b0, "cmd_rdy after acceptance"); // no second take.
  endtask

  task automatic issue_write(input uart_cmd_pkg::reg_addr_t a, input uart_cmd_pkg::uart_byte_t d);
    shadow[a]  = d;
    written[a] = 1'b1;
    drive_cmd({uart_cmd_pkg::op_write, a, d});
  endtask

  task automatic issue_read(input uart_cmd_pkg::reg_addr_t a,
                            input uart_cmd_pkg::uart_byte_t exp_d, input logic exp_e);
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    reads_issued++;
    drive_cmd({uart_cmd_pkg::op_read, a, 8'h00});
  endtask

  task automatic wait_reads();
    while (reads_done != reads_issued) @(negedge clk);
  endtask

  task automatic wait_idle();
    while (!cmd_rdy) @(negedge clk);
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (rst_n && cmd_vld && cmd_rdy)
      accepts++;
    if (frame_err)
      fail_now("slave model got a command frame with bad parity or a low stop bit");
    else if (cycles >= timeout_cycles)
      fail_now($sformatf("timeout, run did not finish within %0d cycles", timeout_cycles));
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      if (exp_data_q.size() == 0)
      begin
        fail_now("read_rdy pulsed with no read outstanding");
      end
      else
      begin
        want_data = exp_data_q.pop_front();
        want_err  = exp_err_q.pop_front();
        check_byte(read_data, want_data, "read_data");
        check_flag(read_err, want_err, "read_err");
        reads_done++;
      end
    end
  end

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    silent         = 1'b0;
    rand_state     = 32'h7c25;
    for (int i = 0; i < 128; i++)
    begin
      written[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag(tx, 1'b1, "tx after reset");
    check_flag(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_flag(read_rdy, 1'b0, "read_rdy after reset");

    // cmd_vld stays high between pairs, so each read waits behind a write.
    for (int i = 0; i < num_pairs; i++)
    begin
      rand_state = next_random(rand_state);
      waddr      = rand_state[6:0];
      issue_write(waddr, rand_state[15:8]);
      rand_state = next_random(rand_state);
      raddr      = rand_state[31] ? waddr : rand_state[6:0];
      issue_read(raddr, expected_read(raddr), 1'b0);
    end
    cmd_vld = 1'b0;
    wait_reads();

    corrupt_parity = 1'b1;
    rand_state     = next_random(rand_state);
    raddr          = rand_state[6:0];
    issue_read(raddr, expected_read(raddr), 1'b1);
    cmd_vld = 1'b0;
    wait_reads();
    corrupt_parity = 1'b0;

    silent = 1'b1;
    issue_read(raddr, 8'h00, 1'b1); // no answer.
    cmd_vld = 1'b0;
    wait_reads();
    silent = 1'b0;
    issue_read(waddr, expected_read(waddr), 1'b0);
    cmd_vld = 1'b0;
    wait_reads();

    wait_idle();
    rand_state = next_random(rand_state);
    issue_write(rand_state[6:0], rand_state[15:8]);
    cmd_vld    = 1'b0;
    turnaround = 0;
    while (!cmd_rdy)
    begin
      @(negedge clk);
      turnaround++;
    end
    check_count(turnaround, write_cycles, "write turnaround cycles");

    check_count(accepts, cmds_issued, "accepted commands");
    check_count(addr_frames, cmds_issued, "address frames at the slave");
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== uart_cmd_top.f ====
verilog/uart_cmd_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_frame_tx.sv
verilog/uart_frame_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_cmd_top.sv
bench/uart_slave_model.sv
bench/uart_cmd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart command master testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module uart_cmd_tb \
  -f uart_cmd_top.f \
  -Mdir obj_dir \
  && ./obj_dir/Vuart_cmd_tb \
  || { echo "simulation failed"; exit 1; }
